// File: fetch_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fetch package: shared word, hart and
// fetch/execute entry types for the multi-hart fetch block
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package fetch_pkg;

    // Instruction or address word
    typedef logic [31:0] word_t;

    // Hart index, up to four harts
    typedef logic [1:0] hart_id_t;

    // Reset PC offset between neighbouring harts
    localparam word_t HART_PC_STRIDE = 32'h0000_1000;

    // Entry handed from fetch to execute
    typedef struct packed {
        word_t    instr;
        word_t    pc;
        word_t    pc4;
        // Faulting address, meaningful only with an exception flag
        word_t    badaddr;
        hart_id_t hart_id;
        // PC not word aligned
        logic     mal_insn;
        // Bus error on the instruction access
        logic     fault_insn;
    } fetch_entry_t;

    // Branch redirect strobe from execute
    typedef struct packed {
        logic     valid;
        hart_id_t hart_id;
        word_t    target;
    } redirect_t;

endpackage

// File: hart_selector.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Hart selector: round-robin pointer over
// the enabled harts, advanced on each fetch
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module hart_selector import fetch_pkg::*; #(
    parameter int NUM_HARTS = 3
) (
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic [NUM_HARTS-1:0] hart_en,
    input  logic                 fetch_done,
    output hart_id_t             cur_hart
);

    hart_id_t next_hart;
    logic     cur_off;

    // Current hart has been masked off
    assign cur_off = !hart_en[cur_hart];

    // Closest enabled hart after the current one, wrapping around
    always_comb begin
        hart_id_t cand;
        next_hart = cur_hart;
        cand = cur_hart;
        // Walk from the farthest offset down so the nearest enabled hart wins
        for (int k = NUM_HARTS; k >= 1; k--) begin
            cand = hart_id_t'((int'(cur_hart) + k) % NUM_HARTS);
            if (hart_en[cand]) begin
                next_hart = cand;
            end
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            // A masked hart 0 is skipped on the first cycle out of reset
            cur_hart <= '0;
        end else if (fetch_done || cur_off) begin
            cur_hart <= next_hart;
        end
    end

    // Pointer never leaves the implemented harts
    a_hart_range: assert property (@(posedge CLK) disable iff (!nRST)
        int'(cur_hart) < NUM_HARTS)
        else $error("cur_hart %0d out of range", cur_hart);

endmodule

// File: hart_pc_file.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Hart PC file: one program counter per hart,
// advanced on fetch and loaded on redirect
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module hart_pc_file import fetch_pkg::*; #(
    parameter int    NUM_HARTS = 3,
    parameter word_t RESET_PC  = 32'h8000_0000
) (
    input  logic                  CLK,
    input  logic                  nRST,
    input  hart_id_t              cur_hart,
    input  logic                  fetch_done,
    input  word_t                 npc,
    input  redirect_t             redirect,
    output word_t [NUM_HARTS-1:0] pcs
);

    genvar h;

    generate
        for (h = 0; h < NUM_HARTS; h++) begin : g_pc
            logic redir_hit;
            logic adv_hit;

            // Redirect aimed at this hart
            assign redir_hit = redirect.valid && (redirect.hart_id == hart_id_t'(h));
            // This hart's instruction was captured this cycle
            assign adv_hit = fetch_done && (cur_hart == hart_id_t'(h));

            always_ff @(posedge CLK, negedge nRST) begin
                if (!nRST) begin
                    // Each hart starts one stride above the previous one
                    pcs[h] <= RESET_PC + word_t'(h) * HART_PC_STRIDE;
                end else if (redir_hit) begin
                    // Redirect wins over the sequential update
                    pcs[h] <= redirect.target;
                end else if (adv_hit) begin
                    pcs[h] <= npc;
                end
            end
        end
    endgenerate

endmodule

// File: fetch_hazard_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fetch hazard control: stall, flush and fetch
// enable from back-pressure and redirects
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module fetch_hazard_ctrl import fetch_pkg::*; (
    input  logic      CLK,
    input  logic      nRST,
    input  logic      ex_valid,
    input  logic      ex_ready,
    input  redirect_t redirect,
    input  hart_id_t  cur_hart,
    input  hart_id_t  held_hart,
    input  logic      i_mem_busy,
    input  logic      fetch_done,
    output logic      stall,
    output logic      flush_fetch,
    output logic      flush_out,
    output logic      iren
);

    logic hit_cur;
    // Flushed fetch still waiting on the bus
    logic discard_q;

    // Output register full and execute not taking it
    assign stall = ex_valid && !ex_ready;

    // Redirect lands on the hart currently being fetched
    assign hit_cur = redirect.valid && (redirect.hart_id == cur_hart);

    // Drop the in-flight fetch now, or its late response later
    assign flush_fetch = hit_cur || discard_q;

    // Held entry belongs to the redirected hart
    assign flush_out = redirect.valid && ex_valid && (redirect.hart_id == held_hart);

    // New fetches only out of reset and while the output register can take a result
    assign iren = nRST && !stall;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            discard_q <= 1'b0;
        end else begin
            // Held until the bus finally answers the dropped access
            discard_q <= flush_fetch && i_mem_busy;
        end
    end

    // A fetch dropped while busy never lands in the output register
    a_no_capture_after_flush: assert property (@(posedge CLK) disable iff (!nRST)
        hit_cur && i_mem_busy |=> !fetch_done)
        else $error("dropped fetch captured after redirect");

endmodule

// File: fetch_stage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fetch stage: instruction bus access, exception
// detection and the fetch/execute register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module fetch_stage import fetch_pkg::*; #(
    parameter int NUM_HARTS         = 3,
    parameter bit BUS_LITTLE_ENDIAN = 1'b1
) (
    input  logic                  CLK,
    input  logic                  nRST,
    input  hart_id_t              cur_hart,
    input  word_t [NUM_HARTS-1:0] pcs,
    input  logic                  stall,
    input  logic                  flush_fetch,
    input  logic                  flush_out,
    input  logic                  iren,
    input  word_t                 imem_rdata,
    input  logic                  imem_busy,
    input  logic                  imem_error,
    input  logic                  ex_ready,
    output word_t                 imem_addr,
    output logic                  imem_ren,
    output word_t                 npc,
    output logic                  fetch_done,
    output logic                  i_mem_busy,
    output hart_id_t              held_hart,
    output fetch_entry_t          ex_entry,
    output logic                  ex_valid
);

    word_t        pc_cur;
    word_t        instr_sw;
    // Address and hart of a request already on the bus
    word_t        req_addr;
    hart_id_t     req_hart;
    logic         req_pend;
    hart_id_t     entry_hart;
    logic         mal_pc;
    logic         fault;
    logic         bus_done;
    logic         stale;
    logic         drop;
    logic         take;
    fetch_entry_t entry_d;

    assign pc_cur = pcs[cur_hart];

    // Bus address and hart stay frozen while a request is outstanding
    assign imem_addr  = req_pend ? req_addr : pc_cur;
    assign entry_hart = req_pend ? req_hart : cur_hart;

    // Misaligned PC never goes out on the bus
    assign mal_pc   = !req_pend && (pc_cur[1:0] != 2'b00);
    assign imem_ren = req_pend || (iren && !mal_pc);

    assign i_mem_busy = imem_ren && imem_busy;
    assign bus_done   = imem_ren && !imem_busy;
    assign fault      = bus_done && imem_error;

    // Selector moved off the requesting hart, so the answer is useless
    assign stale = (entry_hart != cur_hart);
    assign drop  = flush_fetch || stale;

    // Capture on a finished access or a misaligned PC, never while full
    assign take       = !stall && !drop && (bus_done || (iren && mal_pc));
    assign fetch_done = take;

    // Sequential next PC, redirects are applied in the PC file
    assign npc = imem_addr + 32'd4;

    // Bus delivers byte 0 in the low lane when little endian
    assign instr_sw = BUS_LITTLE_ENDIAN ?
        {imem_rdata[7:0], imem_rdata[15:8], imem_rdata[23:16], imem_rdata[31:24]} :
        imem_rdata;

    always_comb begin
        // Exceptions squash the instruction to zero
        entry_d.instr      = (mal_pc || fault) ? '0 : instr_sw;
        entry_d.pc         = imem_addr;
        entry_d.pc4        = imem_addr + 32'd4;
        entry_d.badaddr    = imem_addr;
        entry_d.hart_id    = entry_hart;
        entry_d.mal_insn   = mal_pc;
        entry_d.fault_insn = fault;
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            req_pend <= 1'b0;
            ex_valid <= 1'b0;
        end else begin
            // Keep asking while busy, or repeat a finished access blocked by a stall
            req_pend <= imem_ren && (imem_busy || (stall && !drop));
            if (take) begin
                ex_valid <= 1'b1;
            end else if (flush_out || ex_ready) begin
                ex_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK) begin
        req_addr <= imem_addr;
        req_hart <= entry_hart;
        if (take) begin
            ex_entry <= entry_d;
        end
    end

    assign held_hart = ex_entry.hart_id;

    // Held entry does not move until execute takes it or it is flushed
    a_entry_stable: assert property (@(posedge CLK) disable iff (!nRST)
        ex_valid && !ex_ready && !flush_out |=> ex_valid && $stable(ex_entry))
        else $error("ex_entry changed while held");

    // Bus request and address hold until busy drops
    a_bus_hold: assert property (@(posedge CLK) disable iff (!nRST)
        imem_ren && imem_busy |=> imem_ren && $stable(imem_addr))
        else $error("bus request dropped while busy");

endmodule

// File: fetch_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fetch top: multi-hart RV32I fetch block
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module fetch_top import fetch_pkg::*; #(
    parameter int    NUM_HARTS         = 3,
    parameter word_t RESET_PC          = 32'h8000_0000,
    parameter bit    BUS_LITTLE_ENDIAN = 1'b1
) (
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic [NUM_HARTS-1:0] hart_en,
    input  redirect_t            redirect,
    output fetch_entry_t         ex_entry,
    output logic                 ex_valid,
    input  logic                 ex_ready,
    output word_t                imem_addr,
    output logic                 imem_ren,
    input  word_t                imem_rdata,
    input  logic                 imem_busy,
    input  logic                 imem_error
);

    hart_id_t              cur_hart;
    hart_id_t              held_hart;
    word_t [NUM_HARTS-1:0] pcs;
    word_t                 npc;
    logic                  fetch_done;
    logic                  i_mem_busy;
    logic                  stall;
    logic                  flush_fetch;
    logic                  flush_out;
    logic                  iren;

    hart_selector #(.NUM_HARTS(NUM_HARTS)) u_hart_selector (
        .CLK        (CLK),
        .nRST       (nRST),
        .hart_en    (hart_en),
        .fetch_done (fetch_done),
        .cur_hart   (cur_hart)
    );

    hart_pc_file #(.NUM_HARTS(NUM_HARTS), .RESET_PC(RESET_PC)) u_hart_pc_file (
        .CLK        (CLK),
        .nRST       (nRST),
        .cur_hart   (cur_hart),
        .fetch_done (fetch_done),
        .npc        (npc),
        .redirect   (redirect),
        .pcs        (pcs)
    );

    fetch_hazard_ctrl u_fetch_hazard_ctrl (
        .CLK         (CLK),
        .nRST        (nRST),
        .ex_valid    (ex_valid),
        .ex_ready    (ex_ready),
        .redirect    (redirect),
        .cur_hart    (cur_hart),
        .held_hart   (held_hart),
        .i_mem_busy  (i_mem_busy),
        .fetch_done  (fetch_done),
        .stall       (stall),
        .flush_fetch (flush_fetch),
        .flush_out   (flush_out),
        .iren        (iren)
    );

    fetch_stage #(
        .NUM_HARTS         (NUM_HARTS),
        .BUS_LITTLE_ENDIAN (BUS_LITTLE_ENDIAN)
    ) u_fetch_stage (
        .CLK         (CLK),
        .nRST        (nRST),
        .cur_hart    (cur_hart),
        .pcs         (pcs),
        .stall       (stall),
        .flush_fetch (flush_fetch),
        .flush_out   (flush_out),
        .iren        (iren),
        .imem_rdata  (imem_rdata),
        .imem_busy   (imem_busy),
        .imem_error  (imem_error),
        .ex_ready    (ex_ready),
        .imem_addr   (imem_addr),
        .imem_ren    (imem_ren),
        .npc         (npc),
        .fetch_done  (fetch_done),
        .i_mem_busy  (i_mem_busy),
        .held_hart   (held_hart),
        .ex_entry    (ex_entry),
        .ex_valid    (ex_valid)
    );

endmodule

// File: tb_clock_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock and active-low reset
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD       = 8,
    parameter int RESET_CYCLES = 4
) (
    output logic CLK,
    output logic nRST
);

    initial begin
        CLK = 1'b0;
        forever #(PERIOD / 2) CLK = ~CLK;
    end

    // Reset released on a rising edge after the reset cycles
    initial begin
        nRST = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        nRST <= 1'b1;
    end

endmodule

// File: tb_imem.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction memory model with random busy
// latency and an error window
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_imem import fetch_pkg::*; #(
    parameter int SEED = 32'hc9bb_7368
) (
    input  logic  CLK,
    input  logic  nRST,
    input  word_t imem_addr,
    input  logic  imem_ren,
    output word_t imem_rdata,
    output logic  imem_busy,
    output logic  imem_error
);

    // Busy cycles left on the current access
    logic [1:0] wait_cnt;
    integer     seed;

    initial begin
        seed = SEED;
    end

    // Word address tagged into the data, so a wrong address shows in instr
    assign imem_rdata = {2'b00, imem_addr[31:2]} ^ 32'h5A5A_0000;
    // Error window where address bits 15:12 are 0xE
    assign imem_error = (imem_addr[15:12] == 4'hE);
    assign imem_busy  = (wait_cnt != 2'd0);

    always @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            wait_cnt <= 2'd0;
        end else if (imem_ren) begin
            if (wait_cnt != 2'd0) begin
                wait_cnt <= wait_cnt - 2'd1;
            end else begin
                // Access answered, pick latency of the next one
                wait_cnt <= 2'($random(seed));
            end
        end
    end

endmodule

// File: tb_fetch_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fetch block testbench: back-pressure, redirects,
// exceptions and hart masking against a per-hart PC model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_fetch_top import fetch_pkg::*; ();

    localparam int       NUM_HARTS  = 3;
    localparam word_t    RESET_PC   = 32'h8000_0000;
    localparam int       SEED       = 32'hc9bb_7368;
    localparam int       N_TOTAL    = 150;
    localparam int       MAX_CYCLES = N_TOTAL * 20 + 200;
    localparam int       N_EVENTS   = 5;
    localparam int       DISABLE_AT = 105;
    localparam hart_id_t DIS_HART   = 2'd1;
    // Redirects: aligned, misaligned, error window, then back to plain code
    localparam int       EV_AT [N_EVENTS] = '{30, 45, 60, 80, 90};
    localparam hart_id_t EV_HART [N_EVENTS] = '{2'd1, 2'd2, 2'd0, 2'd2, 2'd0};
    localparam word_t    EV_TARGET [N_EVENTS] = '{32'h8000_4000, 32'h8000_5002,
        32'h8000_E000, 32'h8000_6000, 32'h8000_7000};

    logic                 CLK;
    logic                 nRST;
    logic [NUM_HARTS-1:0] hart_en;
    redirect_t            redirect;
    logic                 ex_ready;
    fetch_entry_t         ex_entry;
    logic                 ex_valid;
    word_t                imem_addr;
    logic                 imem_ren;
    word_t                imem_rdata;
    logic                 imem_busy;
    logic                 imem_error;

    // Reference model state, one expected PC per hart
    word_t    exp_pc [4];
    hart_id_t last_hart;
    int       resync;
    int       dis_cnt;
    int       n_xfer;
    int       step;
    int       err_cnt;
    logic     dis_active;
    logic     mal_seen;
    logic     fault_seen;
    integer   seed;

    logic     xfer;
    word_t    exp_pc_cur;
    logic     exp_mal;
    logic     exp_fault;
    word_t    exp_instr;
    hart_id_t exp_hart;

    tb_clock_gen #(.PERIOD(8), .RESET_CYCLES(4)) u_clock_gen (.CLK(CLK), .nRST(nRST));

    tb_imem #(.SEED(SEED)) u_imem (
        .CLK        (CLK),
        .nRST       (nRST),
        .imem_addr  (imem_addr),
        .imem_ren   (imem_ren),
        .imem_rdata (imem_rdata),
        .imem_busy  (imem_busy),
        .imem_error (imem_error)
    );

    fetch_top #(
        .NUM_HARTS         (NUM_HARTS),
        .RESET_PC          (RESET_PC),
        .BUS_LITTLE_ENDIAN (1'b1)
    ) u_fetch_top (
        .CLK        (CLK),
        .nRST       (nRST),
        .hart_en    (hart_en),
        .redirect   (redirect),
        .ex_entry   (ex_entry),
        .ex_valid   (ex_valid),
        .ex_ready   (ex_ready),
        .imem_addr  (imem_addr),
        .imem_ren   (imem_ren),
        .imem_rdata (imem_rdata),
        .imem_busy  (imem_busy),
        .imem_error (imem_error)
    );

    // Memory word as stored, byte 0 in the low lane
    function automatic word_t mem_word(word_t addr);
        return {2'b00, addr[31:2]} ^ 32'h5A5A_0000;
    endfunction

    function automatic word_t byte_swap(word_t w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    // Next hart in round-robin order among the enabled ones
    function automatic hart_id_t next_enabled(hart_id_t last, logic [NUM_HARTS-1:0] mask);
        int h;
        h = int'(last);
        for (int k = 0; k < NUM_HARTS; k++) begin
            h = (h + 1) % NUM_HARTS;
            if (mask[h]) begin
                return hart_id_t'(h);
            end
        end
        return last;
    endfunction

    task automatic report_mismatch(string name, word_t exp, word_t act);
        $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
        err_cnt++;
    endtask

    task automatic report_error(string what);
        $display("[ERROR] %s", what);
        err_cnt++;
    endtask

    assign xfer       = ex_valid && ex_ready;
    assign exp_pc_cur = exp_pc[ex_entry.hart_id];
    assign exp_mal    = (exp_pc_cur[1:0] != 2'b00);
    // Misaligned PC never reaches the bus, so it cannot fault
    assign exp_fault  = !exp_mal && (exp_pc_cur[15:12] == 4'hE);
    assign exp_instr  = (exp_mal || exp_fault) ? 32'd0 : byte_swap(mem_word(exp_pc_cur));
    assign exp_hart   = next_enabled(last_hart, hart_en);

    initial begin
        seed     = SEED;
        err_cnt  = 0;
        hart_en  = '1;
        redirect = '0;
        ex_ready = 1'b0;
    end

    // Scoreboard update on each transfer, then the next stimulus
    always @(posedge CLK) begin
        if (!nRST) begin
            for (int h = 0; h < 4; h++) begin
                exp_pc[h] <= RESET_PC + word_t'(h) * HART_PC_STRIDE;
            end
            last_hart  <= hart_id_t'(NUM_HARTS - 1);
            resync     <= 0;
            dis_cnt    <= 0;
            n_xfer     <= 0;
            step       <= 0;
            dis_active <= 1'b0;
            mal_seen   <= 1'b0;
            fault_seen <= 1'b0;
        end else begin
            redirect <= '0;
            // Execute ready about three cycles out of four
            ex_ready <= (($random(seed) & 3) != 0);
            if (xfer) begin
                exp_pc[ex_entry.hart_id] <= exp_pc_cur + 32'd4;
                last_hart <= ex_entry.hart_id;
                n_xfer    <= n_xfer + 1;
                if (resync != 0) begin
                    resync <= resync - 1;
                end
                if (dis_active) begin
                    dis_cnt <= dis_cnt + 1;
                end
                if (ex_entry.mal_insn) begin
                    mal_seen <= 1'b1;
                end
                if (ex_entry.fault_insn) begin
                    fault_seen <= 1'b1;
                end
            end
            if (step < N_EVENTS && n_xfer >= EV_AT[step]) begin
                redirect <= {1'b1, EV_HART[step], EV_TARGET[step]};
                // No transfer in the redirect cycle, a held entry of that hart is dropped
                ex_ready <= 1'b0;
                exp_pc[EV_HART[step]] <= EV_TARGET[step];
                resync <= 1;
                step   <= step + 1;
            end else if (step == N_EVENTS && !dis_active && n_xfer >= DISABLE_AT) begin
                hart_en[DIS_HART] <= 1'b0;
                dis_active <= 1'b1;
                dis_cnt    <= 0;
                // Held entry and one capture of the masked hart may still drain
                resync     <= 2;
            end
        end
    end

    a_reset_quiet: assert property (@(negedge CLK) (!nRST || $rose(nRST)) |-> !ex_valid)
        else report_error("ex_valid high during or right after reset");

    a_reset_no_fetch: assert property (@(negedge CLK) !nRST |-> !imem_ren)
        else report_error("imem_ren high during reset");

    a_pc: assert property (@(negedge CLK) disable iff (!nRST)
        xfer |-> ex_entry.pc == exp_pc_cur)
        else report_mismatch("pc_sequence", exp_pc_cur, ex_entry.pc);

    a_pc4: assert property (@(negedge CLK) disable iff (!nRST)
        xfer |-> ex_entry.pc4 == exp_pc_cur + 32'd4)
        else report_mismatch("pc4", exp_pc_cur + 32'd4, ex_entry.pc4);

    a_instr: assert property (@(negedge CLK) disable iff (!nRST)
        xfer |-> ex_entry.instr == exp_instr)
        else report_mismatch("instr", exp_instr, ex_entry.instr);

    a_flags: assert property (@(negedge CLK) disable iff (!nRST)
        xfer |-> {ex_entry.mal_insn, ex_entry.fault_insn} == {exp_mal, exp_fault})
        else report_mismatch("exception_flags", {30'd0, exp_mal, exp_fault},
            {30'd0, ex_entry.mal_insn, ex_entry.fault_insn});

    a_badaddr: assert property (@(negedge CLK) disable iff (!nRST)
        xfer && (exp_mal || exp_fault) |-> ex_entry.badaddr == exp_pc_cur)
        else report_mismatch("badaddr", exp_pc_cur, ex_entry.badaddr);

    a_order: assert property (@(negedge CLK) disable iff (!nRST)
        xfer && resync == 0 |-> ex_entry.hart_id == exp_hart)
        else report_mismatch("round_robin", {30'd0, exp_hart}, {30'd0, ex_entry.hart_id});

    a_hold: assert property (@(negedge CLK) disable iff (!nRST)
        ex_valid && !ex_ready && !redirect.valid |=> ex_valid && $stable(ex_entry))
        else report_error("ex_entry changed or vanished while execute was not ready");

    a_masked: assert property (@(negedge CLK) disable iff (!nRST)
        xfer && dis_active && dis_cnt >= 2 |-> ex_entry.hart_id != DIS_HART)
        else report_error("entry of a masked hart reached execute");

    initial begin
        wait (nRST === 1'b1);
        while (n_xfer < N_TOTAL) begin
            @(posedge CLK);
        end
        repeat (2) @(negedge CLK);
        if (!mal_seen) begin
            report_error("no misaligned-PC entry reached execute");
        end
        if (!fault_seen) begin
            report_error("no bus-error entry reached execute");
        end
        $display("errors: %0d, entries checked: %0d", err_cnt, n_xfer);
        if (err_cnt == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // Watchdog, 20 cycles per expected entry plus margin
    initial begin
        repeat (MAX_CYCLES) @(posedge CLK);
        $display("[ERROR] watchdog expired after %0d cycles with %0d of %0d entries",
            MAX_CYCLES, n_xfer, N_TOTAL);
        $display("errors: %0d, entries checked: %0d", err_cnt + 1, n_xfer);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// File: src.f
fetch_pkg.sv
hart_selector.sv
hart_pc_file.sv
fetch_hazard_ctrl.sv
fetch_stage.sv
fetch_top.sv
tb_clock_gen.sv
tb_imem.sv
tb_fetch_top.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the fetch block testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing --top-module tb_fetch_top -f src.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_fetch_top)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "RESULT: PASS"; then
    exit 0
fi
exit 1
